// File: rtl/core_pkg.sv
// Core package: instruction format, opcodes, debug commands and pipeline payloads
package core_pkg;

	localparam int data_width = 32;
	localparam int reg_count = 32;

	// Instruction field positions
	localparam int op_msb = 31;
	localparam int op_lsb = 27;
	localparam int dest_msb = 26;
	localparam int dest_lsb = 22;
	localparam int src0_msb = 21;
	localparam int src0_lsb = 17;
	localparam int src1_msb = 16;
	localparam int src1_lsb = 12;
	localparam int imm_msb = 15;
	localparam int imm_lsb = 0;

	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
	typedef logic [data_width-1:0] word_t;
	typedef logic [31:0] pc_t;

	// Opcode values 0 to 9, anything above decodes as op_nop
	typedef enum logic [4:0] {
		op_nop,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_shr,
		op_addi,
		op_jump
	} op_e;

	typedef enum logic [1:0] {
		cmd_stop,
		cmd_start,
		cmd_read_gr,
		cmd_write_gr
	} debug_cmd_e;

	typedef struct packed {
		word_t inst;
		pc_t pc;
	} fetch_item_t;

	typedef struct packed {
		op_e op;
		reg_idx_t dest;
		reg_idx_t src0;
		reg_idx_t src1;
		word_t imm;
		logic writeback;
		pc_t pc;
	} decoded_op_t;

	typedef struct packed {
		op_e op;
		reg_idx_t dest;
		word_t operand0;
		word_t operand1;
		logic writeback;
	} issue_op_t;

endpackage

// File: rtl/reg_debug_if.sv
// Register debug interface: debug unit access to the general register file
interface reg_debug_if;
	import core_pkg::*;

	reg_idx_t index;
	logic write;
	word_t write_data;
	// Combinational read of the indexed register
	word_t read_data;

	modport debug_mp (output index, output write, output write_data, input read_data);
	modport regfile_mp (input index, input write, input write_data, output read_data);

endinterface

// File: rtl/fetch.sv
// Fetch unit: keeps the PC, issues one instruction request at a time, feeds the decoder
module fetch (
	input logic clock,
	input logic reset,
	input logic inst_busy,
	input logic inst_valid,
	input core_pkg::word_t inst_data,
	output logic inst_req,
	output core_pkg::pc_t inst_addr,
	input logic flush,
	input core_pkg::pc_t flush_pc,
	output logic next_valid,
	output core_pkg::fetch_item_t next_item,
	input logic next_lock
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_wait,
		fetch_hold
	} fetch_state_e;

	fetch_state_e state;
	pc_t pc;
	// Response still owed for an address made stale by a flush
	logic drop;

	assign inst_addr = pc;
	assign next_valid = (state == fetch_hold);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_idle;
			inst_req <= 1'b0;
			pc <= '0;
			drop <= 1'b0;
		end else begin
			case (state)
				fetch_idle: begin
					if (inst_req && !inst_busy) begin
						inst_req <= 1'b0;
						drop <= flush;
						state <= fetch_wait;
					end else begin
						inst_req <= 1'b1;
					end
				end
				fetch_wait: begin
					if (inst_valid) begin
						drop <= 1'b0;
						if (drop || flush) begin
							inst_req <= 1'b1;
							state <= fetch_idle;
						end else begin
							pc <= pc + 32'd4;
							state <= fetch_hold;
						end
					end else if (flush) begin
						drop <= 1'b1;
					end
				end
				fetch_hold: begin
					if (flush || !next_lock) begin
						inst_req <= 1'b1;
						state <= fetch_idle;
					end
				end
				default: state <= fetch_idle;
			endcase
			// Redirect wins over the sequential step
			if (flush)
				pc <= flush_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (state == fetch_wait && inst_valid) begin
			next_item.inst <= inst_data;
			next_item.pc <= pc;
		end
	end

endmodule

// File: rtl/decoder.sv
// Decoder: splits an instruction into fields and registers the decoded operation
module decoder (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic prev_valid,
	input core_pkg::fetch_item_t prev_item,
	output logic prev_lock,
	output logic next_valid,
	output core_pkg::decoded_op_t next_op,
	input logic next_lock
);
	import core_pkg::*;

	decoded_op_t dec;
	logic [op_msb-op_lsb:0] opcode;

	assign opcode = prev_item.inst[op_msb:op_lsb];
	assign prev_lock = next_valid && next_lock;

	always_comb begin
		// Unknown opcodes fall back to op_nop
		if (opcode > 5'(op_jump))
			dec.op = op_nop;
		else
			dec.op = op_e'(opcode);
		dec.dest = prev_item.inst[dest_msb:dest_lsb];
		dec.src0 = prev_item.inst[src0_msb:src0_lsb];
		dec.src1 = prev_item.inst[src1_msb:src1_lsb];
		dec.imm = {{(data_width-16){prev_item.inst[imm_msb]}}, prev_item.inst[imm_msb:imm_lsb]};
		dec.writeback = (dec.op != op_nop) && (dec.op != op_jump);
		dec.pc = prev_item.pc;
	end

	always_ff @(posedge clock) begin
		if (reset)
			next_valid <= 1'b0;
		else if (flush)
			next_valid <= 1'b0;
		else if (!prev_lock)
			next_valid <= prev_valid;
	end

	always_ff @(posedge clock) begin
		if (!prev_lock && prev_valid)
			next_op <= dec;
	end

endmodule

// File: rtl/dispatch.sv
// Dispatch stage: register file, operand read, hazard stall and halt control
module dispatch (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic halt,
	output logic halted,
	input logic prev_valid,
	input core_pkg::decoded_op_t prev_op,
	output logic prev_lock,
	output logic exec_valid,
	output core_pkg::issue_op_t exec_op,
	input logic wb_valid,
	input core_pkg::reg_idx_t wb_dest,
	input core_pkg::word_t wb_data,
	reg_debug_if.regfile_mp dbg
);
	import core_pkg::*;

	word_t regs [reg_count];
	logic hazard;
	logic take;
	word_t operand0;
	word_t operand1;

	// Producer in the output register writes at the end of this cycle
	assign hazard = prev_valid && exec_valid && exec_op.writeback &&
		(prev_op.src0 == exec_op.dest || prev_op.src1 == exec_op.dest);
	assign take = prev_valid && !hazard && !halt;
	assign prev_lock = hazard || halt;
	assign halted = halt && !exec_valid;

	assign dbg.read_data = regs[dbg.index];

	// Immediate replaces source 1 for addi and carries the jump target
	assign operand0 = regs[prev_op.src0];
	assign operand1 = (prev_op.op == op_addi || prev_op.op == op_jump) ?
		prev_op.imm : regs[prev_op.src1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (dbg.write) begin
			regs[dbg.index] <= dbg.write_data;
		end else if (wb_valid) begin
			regs[wb_dest] <= wb_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			exec_valid <= 1'b0;
		else if (flush)
			exec_valid <= 1'b0;
		else
			exec_valid <= take;
	end

	always_ff @(posedge clock) begin
		if (take) begin
			exec_op.op <= prev_op.op;
			exec_op.dest <= prev_op.dest;
			exec_op.operand0 <= operand0;
			exec_op.operand1 <= operand1;
			exec_op.writeback <= prev_op.writeback;
		end
	end

endmodule

// File: rtl/execute.sv
// Execute stage: single-cycle ALU, writeback and jump resolution
module execute (
	input logic exec_valid,
	input core_pkg::issue_op_t exec_op,
	output logic wb_valid,
	output core_pkg::reg_idx_t wb_dest,
	output core_pkg::word_t wb_data,
	output logic flush,
	output core_pkg::pc_t flush_pc
);
	import core_pkg::*;

	word_t result;
	logic [4:0] shamt;

	assign shamt = exec_op.operand1[4:0];

	always_comb begin
		case (exec_op.op)
			op_add, op_addi: result = exec_op.operand0 + exec_op.operand1;
			op_sub: result = exec_op.operand0 - exec_op.operand1;
			op_and: result = exec_op.operand0 & exec_op.operand1;
			op_or: result = exec_op.operand0 | exec_op.operand1;
			op_xor: result = exec_op.operand0 ^ exec_op.operand1;
			op_shl: result = exec_op.operand0 << shamt;
			op_shr: result = exec_op.operand0 >> shamt;
			default: result = '0;
		endcase
	end

	assign wb_valid = exec_valid && exec_op.writeback;
	assign wb_dest = exec_op.dest;
	assign wb_data = result;

	// Jump target is imm16 as a word index
	assign flush = exec_valid && (exec_op.op == op_jump);
	assign flush_pc = {14'b0, exec_op.operand1[15:0], 2'b00};

endmodule

// File: rtl/core_debug.sv
// Debug unit: stop and start the core, register read and write while stopped
module core_debug (
	input logic clock,
	input logic reset,
	input logic cmd_req,
	output logic cmd_busy,
	input core_pkg::debug_cmd_e cmd_command,
	input core_pkg::reg_idx_t cmd_target,
	input core_pkg::word_t cmd_data,
	output logic resp_valid,
	output logic resp_error,
	output core_pkg::word_t resp_data,
	output logic halt,
	input logic halted,
	reg_debug_if.debug_mp regs
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		dbg_idle,
		dbg_wait_halt,
		dbg_respond
	} dbg_state_e;

	dbg_state_e state;
	logic accept;

	assign accept = cmd_req && (state == dbg_idle);
	assign cmd_busy = (state != dbg_idle);
	assign resp_valid = (state == dbg_respond);

	// Register access goes straight through on the accept edge
	assign regs.index = cmd_target;
	assign regs.write_data = cmd_data;
	assign regs.write = accept && (cmd_command == cmd_write_gr) && halted;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= dbg_idle;
			halt <= 1'b0;
			resp_error <= 1'b0;
		end else begin
			case (state)
				dbg_idle: begin
					if (accept) begin
						case (cmd_command)
							cmd_stop: begin
								halt <= 1'b1;
								resp_error <= 1'b0;
								state <= dbg_wait_halt;
							end
							cmd_start: begin
								halt <= 1'b0;
								resp_error <= 1'b0;
								state <= dbg_respond;
							end
							default: begin
								// Running core refuses register access
								resp_error <= !halted;
								state <= dbg_respond;
							end
						endcase
					end
				end
				dbg_wait_halt: begin
					if (halted)
						state <= dbg_respond;
				end
				default: state <= dbg_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			resp_data <= (cmd_command == cmd_read_gr && halted) ? regs.read_data : '0;
	end

endmodule

// File: rtl/core_pipeline.sv
// Core pipeline top: fetch, decode, dispatch, execute and the debug unit
module core_pipeline (
	input logic clock,
	input logic reset,
	output logic core_flash,
	output logic inst_req,
	input logic inst_busy,
	output core_pkg::pc_t inst_addr,
	input logic inst_valid,
	input core_pkg::word_t inst_data,
	input logic debug_cmd_req,
	output logic debug_cmd_busy,
	input core_pkg::debug_cmd_e debug_cmd_command,
	input core_pkg::reg_idx_t debug_cmd_target,
	input core_pkg::word_t debug_cmd_data,
	output logic debug_cmd_valid,
	output logic debug_cmd_error,
	output core_pkg::word_t debug_resp_data
);
	import core_pkg::*;

	// Fetch to decoder
	logic fetch_valid;
	fetch_item_t fetch_item;
	logic decoder_lock;
	// Decoder to dispatch
	logic decode_valid;
	decoded_op_t decode_op;
	logic dispatch_lock;
	// Dispatch to execute and writeback
	logic exec_valid;
	issue_op_t exec_op;
	logic wb_valid;
	reg_idx_t wb_dest;
	word_t wb_data;
	pc_t flush_pc;
	logic halt;
	logic halted;

	reg_debug_if dbg_regs ();

	fetch fetch_i (
		.clock(clock),
		.reset(reset),
		.inst_busy(inst_busy),
		.inst_valid(inst_valid),
		.inst_data(inst_data),
		.inst_req(inst_req),
		.inst_addr(inst_addr),
		.flush(core_flash),
		.flush_pc(flush_pc),
		.next_valid(fetch_valid),
		.next_item(fetch_item),
		.next_lock(decoder_lock)
	);

	decoder decoder_i (
		.clock(clock),
		.reset(reset),
		.flush(core_flash),
		.prev_valid(fetch_valid),
		.prev_item(fetch_item),
		.prev_lock(decoder_lock),
		.next_valid(decode_valid),
		.next_op(decode_op),
		.next_lock(dispatch_lock)
	);

	dispatch dispatch_i (
		.clock(clock),
		.reset(reset),
		.flush(core_flash),
		.halt(halt),
		.halted(halted),
		.prev_valid(decode_valid),
		.prev_op(decode_op),
		.prev_lock(dispatch_lock),
		.exec_valid(exec_valid),
		.exec_op(exec_op),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.dbg(dbg_regs.regfile_mp)
	);

	execute execute_i (
		.exec_valid(exec_valid),
		.exec_op(exec_op),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.flush(core_flash),
		.flush_pc(flush_pc)
	);

	core_debug core_debug_i (
		.clock(clock),
		.reset(reset),
		.cmd_req(debug_cmd_req),
		.cmd_busy(debug_cmd_busy),
		.cmd_command(debug_cmd_command),
		.cmd_target(debug_cmd_target),
		.cmd_data(debug_cmd_data),
		.resp_valid(debug_cmd_valid),
		.resp_error(debug_cmd_error),
		.resp_data(debug_resp_data),
		.halt(halt),
		.halted(halted),
		.regs(dbg_regs.debug_mp)
	);

endmodule

// File: tests/tb_core_pipeline.sv
// Testbench for the core pipeline with instruction memory model, debug driver and directed tests
module tb_core_pipeline;
	import core_pkg::*;

	localparam int mem_words = 256;
	// Five tests, each bounded well below cycles_per_test, plus margin
	localparam int test_count = 5;
	localparam int cycles_per_test = 700;
	localparam int cycle_limit = test_count * cycles_per_test + 500;

	logic clock = 1'b0;
	logic reset;
	logic core_flash;
	logic inst_req;
	logic inst_busy = 1'b0;
	pc_t inst_addr;
	logic inst_valid = 1'b0;
	word_t inst_data = '0;
	logic debug_cmd_req;
	logic debug_cmd_busy;
	debug_cmd_e debug_cmd_command;
	reg_idx_t debug_cmd_target;
	word_t debug_cmd_data;
	logic debug_cmd_valid;
	logic debug_cmd_error;
	word_t debug_resp_data;

	word_t mem [mem_words];
	word_t model_regs [reg_count];
	int error_count = 0;
	int cycle_count = 0;

	// Memory model state
	logic pending = 1'b0;
	int wait_left = 0;
	pc_t req_addr = '0;
	logic [31:0] bus_lfsr = 32'h5fe4;
	logic [31:0] bus_bits;
	pc_t done_addr = '1;
	int done_hits = 0;
	int flash_count = 0;
	logic [31:0] data_lfsr = 32'h5fe4;

	core_pipeline core_pipeline_i (
		.clock(clock),
		.reset(reset),
		.core_flash(core_flash),
		.inst_req(inst_req),
		.inst_busy(inst_busy),
		.inst_addr(inst_addr),
		.inst_valid(inst_valid),
		.inst_data(inst_data),
		.debug_cmd_req(debug_cmd_req),
		.debug_cmd_busy(debug_cmd_busy),
		.debug_cmd_command(debug_cmd_command),
		.debug_cmd_target(debug_cmd_target),
		.debug_cmd_data(debug_cmd_data),
		.debug_cmd_valid(debug_cmd_valid),
		.debug_cmd_error(debug_cmd_error),
		.debug_resp_data(debug_resp_data)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	// Opcode 31 decodes as a nop and the rest of the word follows the address
	function automatic word_t fill_word(input int idx);
		return {5'h1f, 27'(idx)};
	endfunction

	function automatic word_t read_mem(input pc_t addr);
		if (int'(addr / 4) < mem_words)
			return mem[int'(addr / 4)];
		return fill_word(int'(addr / 4));
	endfunction

	function automatic word_t enc_reg(input op_e op, input int dest, input int src0, input int src1);
		return {op, 5'(dest), 5'(src0), 5'(src1), 12'h000};
	endfunction

	function automatic word_t enc_imm(input op_e op, input int dest, input int src0, input int imm);
		return {op, 5'(dest), 5'(src0), 1'b0, 16'(imm)};
	endfunction

	function automatic word_t enc_jump(input int target);
		return {op_jump, 10'h000, 1'b0, 16'(target)};
	endfunction

	// Instruction memory with random busy and a latency of 1 to 4 cycles
	always @(negedge clock) begin
		if (core_flash)
			flash_count = flash_count + 1;
		if (reset) begin
			pending = 1'b0;
			inst_valid = 1'b0;
			inst_busy = 1'b0;
		end else begin
			inst_valid = 1'b0;
			if (pending) begin
				wait_left = wait_left - 1;
				if (wait_left == 0) begin
					pending = 1'b0;
					inst_valid = 1'b1;
					inst_data = read_mem(req_addr);
				end
			end
			take_bits(bus_lfsr, 2, bus_bits);
			inst_busy = (bus_bits[1:0] == 2'b11);
			// Request is taken on the coming rising edge
			if (inst_req && !inst_busy && !pending) begin
				req_addr = inst_addr;
				take_bits(bus_lfsr, 2, bus_bits);
				wait_left = 1 + int'(bus_bits[1:0]);
				pending = 1'b1;
				if (inst_addr == done_addr)
					done_hits = done_hits + 1;
			end
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("** Error: %s is %h, expected %h", name, got, expected);
			error_count = error_count + 1;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("** Error: %s is %h, expected %h", name, got, expected);
			error_count = error_count + 1;
		end
	endtask

	task automatic send_cmd(input debug_cmd_e cmd, input int target, input word_t data,
			output logic error, output word_t resp);
		@(negedge clock);
		debug_cmd_req = 1'b1;
		debug_cmd_command = cmd;
		debug_cmd_target = reg_idx_t'(target);
		debug_cmd_data = data;
		while (debug_cmd_busy)
			@(negedge clock);
		@(negedge clock);
		debug_cmd_req = 1'b0;
		while (!debug_cmd_valid)
			@(negedge clock);
		error = debug_cmd_error;
		resp = debug_resp_data;
	endtask

	task automatic stop_core();
		logic error;
		word_t resp;
		send_cmd(cmd_stop, 0, '0, error, resp);
		check_flag("debug_cmd_error", error, 1'b0);
	endtask

	task automatic start_core();
		logic error;
		word_t resp;
		send_cmd(cmd_start, 0, '0, error, resp);
		check_flag("debug_cmd_error", error, 1'b0);
	endtask

	task automatic read_reg(input int idx, input logic expect_error, output word_t value);
		logic error;
		send_cmd(cmd_read_gr, idx, '0, error, value);
		check_flag("debug_cmd_error", error, expect_error);
	endtask

	task automatic write_reg(input int idx, input word_t value, input logic expect_error);
		logic error;
		word_t resp;
		send_cmd(cmd_write_gr, idx, value, error, resp);
		check_flag("debug_cmd_error", error, expect_error);
	endtask

	// Sequential reference execution from a word index until a jump to itself
	task automatic run_model(input int start);
		int pc;
		int steps;
		logic done;
		word_t inst;
		word_t a;
		word_t b;
		word_t imm;
		logic [4:0] dest;
		pc = start;
		steps = 0;
		done = 1'b0;
		while (!done && steps < mem_words) begin
			inst = mem[pc];
			dest = inst[26:22];
			a = model_regs[inst[21:17]];
			b = model_regs[inst[16:12]];
			imm = {{16{inst[15]}}, inst[15:0]};
			pc = pc + 1;
			case (inst[31:27])
				op_add: model_regs[dest] = a + b;
				op_sub: model_regs[dest] = a - b;
				op_and: model_regs[dest] = a & b;
				op_or: model_regs[dest] = a | b;
				op_xor: model_regs[dest] = a ^ b;
				op_shl: model_regs[dest] = a << b[4:0];
				op_shr: model_regs[dest] = a >> b[4:0];
				op_addi: model_regs[dest] = a + imm;
				op_jump: begin
					if (int'(inst[15:0]) == pc - 1)
						done = 1'b1;
					pc = int'(inst[15:0]);
				end
				default: ;
			endcase
			steps = steps + 1;
		end
	endtask

	// Reset with the core spinning at address 0, then stop it
	task automatic boot();
		for (int i = 0; i < mem_words; i++)
			mem[i] = fill_word(i);
		mem[0] = enc_jump(0);
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		@(negedge clock);
		reset = 1'b1;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		stop_core();
	endtask

	// Redirect the spin loop to the program at word 1 and run up to its final jump
	task automatic launch(input int last);
		int base;
		mem[0] = enc_jump(1);
		done_addr = pc_t'(last * 4);
		base = done_hits;
		start_core();
		// Second fetch of the last word comes only from its own jump
		while (done_hits < base + 2)
			@(negedge clock);
		stop_core();
	endtask

	// Short bursts between stops, so a held op reaches the decoder right behind its producer
	task automatic step_program(input int last);
		int base;
		mem[0] = enc_jump(1);
		done_addr = pc_t'(last * 4);
		base = done_hits;
		while (done_hits < base + 2) begin
			start_core();
			stop_core();
		end
	endtask

	task automatic compare_regs(input int first, input int last);
		word_t value;
		for (int i = first; i <= last; i++) begin
			read_reg(i, 1'b0, value);
			check_word($sformatf("r%0d", i), value, model_regs[i]);
		end
	endtask

	task automatic test_alu();
		boot();
		mem[1] = enc_imm(op_addi, 1, 0, 16'h1234);
		mem[2] = enc_imm(op_addi, 2, 0, -3);
		mem[3] = enc_reg(op_add, 3, 1, 2);
		mem[4] = enc_reg(op_sub, 4, 1, 2);
		mem[5] = enc_reg(op_and, 5, 3, 2);
		mem[6] = enc_reg(op_or, 6, 1, 2);
		mem[7] = enc_reg(op_xor, 7, 3, 4);
		mem[8] = enc_imm(op_addi, 8, 0, 4);
		mem[9] = enc_reg(op_shl, 9, 1, 8);
		mem[10] = enc_reg(op_shr, 10, 2, 8);
		mem[11] = enc_jump(11);
		run_model(1);
		launch(11);
		compare_regs(1, 10);
	endtask

	task automatic test_hazards();
		boot();
		// Every op reads the destination of the one before it
		mem[1] = enc_imm(op_addi, 11, 0, 7);
		mem[2] = enc_reg(op_add, 12, 11, 11);
		mem[3] = enc_reg(op_sub, 13, 12, 11);
		mem[4] = enc_reg(op_shl, 14, 13, 11);
		mem[5] = enc_reg(op_xor, 15, 14, 12);
		mem[6] = enc_reg(op_or, 16, 15, 13);
		mem[7] = enc_reg(op_and, 17, 16, 15);
		mem[8] = enc_imm(op_addi, 18, 17, 16'h7fff);
		mem[9] = enc_reg(op_shr, 19, 18, 11);
		mem[10] = enc_jump(10);
		run_model(1);
		step_program(10);
		compare_regs(11, 19);
	endtask

	task automatic test_jump();
		int base;
		boot();
		mem[1] = enc_imm(op_addi, 20, 0, 1);
		mem[2] = enc_jump(7);
		mem[3] = enc_imm(op_addi, 21, 0, 16'h0055);
		mem[4] = enc_imm(op_addi, 22, 0, 16'h0055);
		mem[5] = enc_imm(op_addi, 23, 0, 16'h0055);
		mem[6] = enc_imm(op_addi, 24, 0, 16'h0055);
		mem[7] = enc_imm(op_addi, 25, 20, 2);
		mem[8] = enc_reg(op_add, 26, 25, 20);
		mem[9] = enc_jump(9);
		run_model(1);
		base = flash_count;
		launch(9);
		compare_regs(20, 26);
		if (flash_count == base) begin
			$display("core_flash was never seen high during the jump test");
			error_count = error_count + 1;
		end
	endtask

	task automatic test_debug_access();
		logic [31:0] value;
		word_t readback;
		boot();
		for (int i = 27; i <= 30; i++) begin
			take_bits(data_lfsr, 32, value);
			write_reg(i, value, 1'b0);
			model_regs[i] = value;
			read_reg(i, 1'b0, readback);
			check_word($sformatf("r%0d", i), readback, value);
		end
		mem[1] = enc_reg(op_add, 31, 27, 28);
		mem[2] = enc_reg(op_xor, 1, 29, 30);
		mem[3] = enc_reg(op_sub, 2, 31, 1);
		mem[4] = enc_reg(op_shr, 3, 27, 29);
		mem[5] = enc_jump(5);
		run_model(1);
		launch(5);
		compare_regs(1, 3);
		compare_regs(27, 31);
	endtask

	task automatic test_error_report();
		word_t value;
		boot();
		mem[1] = enc_imm(op_addi, 5, 0, 16'h0abc);
		mem[2] = enc_imm(op_addi, 6, 5, 1);
		mem[3] = enc_reg(op_xor, 7, 5, 6);
		mem[4] = enc_jump(4);
		run_model(1);
		launch(4);
		start_core();
		// Core spins on its last jump, so register access is refused
		read_reg(5, 1'b1, value);
		write_reg(5, 32'h0badf00d, 1'b1);
		stop_core();
		compare_regs(5, 7);
	endtask

	initial begin
		reset = 1'b1;
		debug_cmd_req = 1'b0;
		debug_cmd_command = cmd_stop;
		debug_cmd_target = '0;
		debug_cmd_data = '0;
		test_alu();
		test_hazards();
		test_jump();
		test_debug_access();
		test_error_report();
		$display("Tests finished with %0d errors", error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: flist.f
rtl/core_pkg.sv
rtl/reg_debug_if.sv
rtl/fetch.sv
rtl/decoder.sv
rtl/dispatch.sv
rtl/execute.sv
rtl/core_debug.sv
rtl/core_pipeline.sv
tests/tb_core_pipeline.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module tb_core_pipeline -o sim_core; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_core)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
	exit 0
fi
exit 1
